//--- common/morse_defines.svh
`ifndef MORSE_DEFINES_SVH
`define MORSE_DEFINES_SVH

// symbol code width, one code per clock
`define MORSE_SYM_W 3

// active-low segments, bit 7 is the decimal point
`define MORSE_SEG_W 8

// tree node encoding width
`define MORSE_NODE_W 6

// valid symbol codes, 101 to 111 are invalid
`define MORSE_SYM_IDLE   3'b000
`define MORSE_SYM_DOT    3'b001
`define MORSE_SYM_DASH   3'b010
`define MORSE_SYM_LETTER 3'b011
`define MORSE_SYM_GAP    3'b100

// special glyphs
`define MORSE_SEG_BLANK 8'hff // all segments dark
`define MORSE_SEG_GAP   8'hf7 // bottom bar between words

`endif

//--- common/morse_pkg.sv
`default_nettype none

`include "morse_defines.svh"

package morse_pkg;

        typedef logic [`MORSE_SYM_W-1:0] sym_t;   // incoming symbol code
        typedef logic [`MORSE_SEG_W-1:0] seg_t;   // active-low, bit 7 = dp

        // one value per position in the morse tree
        typedef enum logic [`MORSE_NODE_W-1:0] {
                node_root,
                // letters
                node_a, node_b, node_c, node_d, node_e, node_f,
                node_g, node_h, node_i, node_j, node_k, node_l,
                node_m, node_n, node_o, node_p, node_q, node_r,
                node_s, node_t, node_u, node_v, node_w, node_x,
                node_y, node_z,
                // digits
                node_one,
                node_two,
                node_three,
                node_four,
                node_five,
                node_six,
                node_seven,
                node_eight,
                // intermediate nodes without a character
                node_ds1,       // ---.
                node_ds3        // ..--
        } morse_node_t;

endpackage

`default_nettype wire

//--- logic/morse_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "morse_defines.svh"

module morse_tree (
        input  wire                  clk,
        input  wire                  rst,
        input  wire morse_pkg::sym_t sym,
        output morse_pkg::morse_node_t node,
        output logic                 letter_done,
        output logic                 word_gap
);

        import morse_pkg::*;

        morse_node_t next_node;
        morse_node_t dot_child;    // where a dot from here leads
        morse_node_t dash_child;   // where a dash from here leads

        // commit strobes go straight from the symbol, no delay
        assign letter_done = (sym == `MORSE_SYM_LETTER);
        assign word_gap    = (sym == `MORSE_SYM_GAP);

        // children of each node; leaves fall back to the root
        always_comb begin
                dot_child  = node_root;
                dash_child = node_root;
                case (node)
                        node_root: begin
                                dot_child  = node_e;
                                dash_child = node_t;
                        end
                        node_e: begin
                                dot_child  = node_i;
                                dash_child = node_a;
                        end
                        node_t: begin
                                dot_child  = node_n;
                                dash_child = node_m;
                        end
                        // second level
                        node_i: begin
                                dot_child  = node_s;
                                dash_child = node_u;
                        end
                        node_a: begin
                                dot_child  = node_r;
                                dash_child = node_w;
                        end
                        node_n: begin
                                dot_child  = node_d;
                                dash_child = node_k;
                        end
                        node_m: begin
                                dot_child  = node_g;
                                dash_child = node_o;
                        end
                        // third level
                        node_s: begin
                                dot_child  = node_h;
                                dash_child = node_v;
                        end
                        node_u: begin
                                dot_child  = node_f;
                                dash_child = node_ds3;   // on the way to 2
                        end
                        node_r:    dot_child = node_l;
                        node_w: begin
                                dot_child  = node_p;
                                dash_child = node_j;
                        end
                        node_d: begin
                                dot_child  = node_b;
                                dash_child = node_x;
                        end
                        node_k: begin
                                dot_child  = node_c;
                                dash_child = node_y;
                        end
                        node_g: begin
                                dot_child  = node_z;
                                dash_child = node_q;
                        end
                        node_o:    dot_child = node_ds1;   // on the way to 8
                        // fourth level, only digit branches remain
                        node_h: begin
                                dot_child  = node_five;
                                dash_child = node_four;
                        end
                        node_v:    dash_child = node_three;
                        node_ds3:  dash_child = node_two;
                        node_j:    dash_child = node_one;
                        node_b:    dot_child = node_six;
                        node_z:    dot_child = node_seven;
                        node_ds1:  dot_child = node_eight;
                        default: begin
                                // leaf: any further dot or dash aborts
                                dot_child  = node_root;
                                dash_child = node_root;
                        end
                endcase
        end

        // symbol decides which way to go
        always_comb begin
                case (sym)
                        `MORSE_SYM_IDLE: next_node = node;         // hold
                        `MORSE_SYM_DOT:  next_node = dot_child;
                        `MORSE_SYM_DASH: next_node = dash_child;
                        default:         next_node = node_root;    // commit or invalid
                endcase
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        node <= node_root;
                end else begin
                        node <= next_node;
                end
        end

endmodule

`default_nettype wire

//--- logic/segment_driver.sv
`timescale 1ns/1ns
`default_nettype none

`include "morse_defines.svh"

module segment_driver (
        input  wire                         clk,
        input  wire                         rst,
        input  wire morse_pkg::morse_node_t node,
        input  wire                         letter_done,
        input  wire                         word_gap,
        output morse_pkg::seg_t             segments
);

        import morse_pkg::*;

        seg_t glyph;    // pattern of the node held this cycle

        // active-low patterns, bit 7 is the decimal point and stays dark
        always_comb begin
                case (node)
                        node_a:     glyph = 8'h88;
                        node_b:     glyph = 8'h83;
                        node_c:     glyph = 8'hc6;
                        node_d:     glyph = 8'ha1;
                        node_e:     glyph = 8'h86;
                        node_f:     glyph = 8'h8e;
                        node_g:     glyph = 8'hc2;
                        node_h:     glyph = 8'h89;
                        node_i:     glyph = 8'hcf;
                        node_j:     glyph = 8'he1;
                        node_k:     glyph = 8'h8a;
                        node_l:     glyph = 8'hc7;
                        node_m:     glyph = 8'haa;
                        node_n:     glyph = 8'hab;
                        node_o:     glyph = 8'hc0;
                        node_p:     glyph = 8'h8c;
                        node_q:     glyph = 8'h98;
                        node_r:     glyph = 8'h9e;
                        node_s:     glyph = 8'h92;
                        node_t:     glyph = 8'h87;
                        node_u:     glyph = 8'hc1;
                        node_v:     glyph = 8'he3;
                        node_w:     glyph = 8'hd5;
                        node_x:     glyph = 8'h89;   // same as h
                        node_y:     glyph = 8'h91;
                        node_z:     glyph = 8'ha4;   // same as 2
                        // digits
                        node_one:   glyph = 8'hf9;
                        node_two:   glyph = 8'ha4;
                        node_three: glyph = 8'hb0;
                        node_four:  glyph = 8'h99;
                        node_five:  glyph = 8'h92;
                        node_six:   glyph = 8'h82;
                        node_seven: glyph = 8'hf8;
                        node_eight: glyph = 8'h80;
                        // root and the intermediate nodes show nothing
                        default:    glyph = `MORSE_SEG_BLANK;
                endcase
        end

        // output only lives for the cycle after a commit
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        segments <= `MORSE_SEG_BLANK;
                end else if (word_gap) begin
                        segments <= `MORSE_SEG_GAP;
                end else if (letter_done) begin
                        segments <= glyph;
                end else begin
                        segments <= `MORSE_SEG_BLANK;
                end
        end

endmodule

`default_nettype wire

//--- logic/morse_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module morse_decoder (
        input  wire                  clk,
        input  wire                  rst,
        input  wire morse_pkg::sym_t sym,
        output morse_pkg::seg_t      segments
);

        import morse_pkg::*;

        morse_node_t node;          // current position in the tree
        logic        letter_done;   // letter end seen this cycle
        logic        word_gap;      // word gap seen this cycle

        // walk the tree and flag commits
        morse_tree i_morse_tree (
                .clk         (clk),
                .rst         (rst),
                .sym         (sym),
                .node        (node),
                .letter_done (letter_done),
                .word_gap    (word_gap)
        );

        // turn the committed node into a registered glyph
        segment_driver i_segment_driver (
                .clk         (clk),
                .rst         (rst),
                .node        (node),
                .letter_done (letter_done),
                .word_gap    (word_gap),
                .segments    (segments)
        );

endmodule

`default_nettype wire

//--- verification/morse_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "morse_defines.svh"

module morse_checker (
        input  wire                  clk,
        input  wire                  rst,
        input  wire morse_pkg::sym_t sym,
        input  wire morse_pkg::seg_t segments,
        input  wire morse_pkg::seg_t expected,
        input  wire [127:0]          test_name,     // up to 16 characters
        input  wire                  check_en,
        input  wire                  flush,
        output logic                 report_done,
        output int                   checks_run,
        output int                   checks_failed,
        output int                   tests_failed
);

        import morse_pkg::*;

        sym_t         sym_q;        // symbol sampled on the last rising edge
        seg_t         exp_q;
        logic [127:0] name_q;
        logic         en_q;
        logic         flush_q;
        logic         in_reset_q;   // reset was low on the last rising edge
        logic [127:0] cur_name;
        logic         in_test;
        int           cur_checks;
        int           cur_errors;
        int           tests_passed;

        initial begin
                report_done   = 1'b0;
                checks_run    = 0;
                checks_failed = 0;
                tests_failed  = 0;
                tests_passed  = 0;
                in_test       = 1'b0;
                cur_name      = '0;
                cur_checks    = 0;
                cur_errors    = 0;
        end

        // one line per finished test
        task automatic close_test();
                if (cur_errors == 0) begin
                        tests_passed++;
                        $display("test %0s passed, %0d checks", cur_name, cur_checks);
                end else begin
                        tests_failed++;
                        $display("test %0s failed, %0d of %0d checks wrong",
                                 cur_name, cur_errors, cur_checks);
                end
        endtask

        // the values that belong to this edge, stable since the falling edge
        always @(posedge clk or negedge rst) begin
                if (!rst) begin
                        sym_q   <= `MORSE_SYM_IDLE;
                        exp_q   <= `MORSE_SEG_BLANK;
                        name_q  <= '0;
                        en_q    <= 1'b0;
                        flush_q <= 1'b0;
                end else begin
                        sym_q   <= sym;
                        exp_q   <= expected;
                        name_q  <= test_name;
                        en_q    <= check_en;
                        flush_q <= flush;
                end
        end

        always @(posedge clk) begin
                in_reset_q <= !rst;
        end

        // segments has settled by the falling edge
        always @(negedge clk) begin
                // output sits at blank while reset is held
                if (in_reset_q) begin
                        checks_run++;
                        if (segments !== `MORSE_SEG_BLANK) begin
                                $display("CHECK FAILED reset: expected %h actual %h",
                                         `MORSE_SEG_BLANK, segments);
                                checks_failed++;
                        end
                end
                if (en_q) begin
                        if (!in_test || name_q != cur_name) begin
                                if (in_test) begin
                                        close_test();
                                end
                                cur_name   = name_q;
                                in_test    = 1'b1;
                                cur_checks = 0;
                                cur_errors = 0;
                        end
                        cur_checks++;
                        checks_run++;
                        if (segments !== exp_q) begin
                                $display("CHECK FAILED %0s: sym %b expected %h actual %h",
                                         name_q, sym_q, exp_q, segments);
                                cur_errors++;
                                checks_failed++;
                        end
                end
                if (flush_q && !report_done) begin
                        if (in_test) begin
                                close_test();
                        end
                        in_test = 1'b0;
                        $display("tests: %0d passed, %0d failed; checks: %0d run, %0d failed",
                                 tests_passed, tests_failed, checks_run, checks_failed);
                        report_done = 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- verification/tb_morse_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "morse_defines.svh"

module tb_morse_decoder;

        import morse_pkg::*;

        localparam int RESET_CYCLES = 2;
        localparam int MAX_IDLE     = 3;    // longest random idle run
        localparam int MARGIN       = 20;

        logic         clk;
        logic         rst;
        sym_t         sym;
        seg_t         segments;
        seg_t         expected;
        logic [127:0] test_name;
        logic         check_en;
        logic         flush;
        logic         report_done;
        int           checks_run;
        int           checks_failed;
        int           tests_failed;
        int           cycle_count = 0;
        int           cycle_limit = 0;

        // one entry per keyed character
        logic [127:0] line_names[$];
        logic [127:0] line_codes[$];
        seg_t         line_expected[$];

        morse_decoder i_morse_decoder (
                .clk      (clk),
                .rst      (rst),
                .sym      (sym),
                .segments (segments)
        );

        morse_checker i_morse_checker (
                .clk           (clk),
                .rst           (rst),
                .sym           (sym),
                .segments      (segments),
                .expected      (expected),
                .test_name     (test_name),
                .check_en      (check_en),
                .flush         (flush),
                .report_done   (report_done),
                .checks_run    (checks_run),
                .checks_failed (checks_failed),
                .tests_failed  (tests_failed)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // number of code characters, or -1 on anything outside 0 to 7
        function automatic int count_codes(logic [127:0] codes);
                logic [7:0] ch;
                int         count;
                count = 0;
                for (int k = 0; k < 16; k++) begin
                        ch = codes[k*8 +: 8];
                        if (ch != 8'h00) begin
                                if (ch < "0" || ch > "7") begin
                                        return -1;
                                end
                                count++;
                        end
                end
                return count;
        endfunction

        task automatic load_stimulus(output int code_count, output logic ok);
                int           fd;
                int           fields;
                string        text;
                logic [127:0] name;
                logic [127:0] codes;
                seg_t         exp_value;
                code_count = 0;
                ok = 1'b1;
                fd = $fopen("verification/morse_stimulus.txt", "r");
                if (fd == 0) begin
                        $display("cannot open the stimulus file verification/morse_stimulus.txt");
                        ok = 1'b0;
                end else begin
                        while (ok && $fgets(text, fd) != 0) begin
                                if (text.len() > 1 && text.getc(0) != "#") begin
                                        fields = $sscanf(text, "%s %s %h", name, codes, exp_value);
                                        if (fields != 3 || count_codes(codes) < 1) begin
                                                $display("malformed stimulus line: %s", text);
                                                ok = 1'b0;
                                        end else begin
                                                line_names.push_back(name);
                                                line_codes.push_back(codes);
                                                line_expected.push_back(exp_value);
                                                code_count += count_codes(codes);
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // key one character, random idles between its codes
        task automatic play_line(input int index);
                logic [127:0] codes;
                logic [7:0]   ch;
                int           remaining;
                int           idle_run;
                codes = line_codes[index];
                remaining = count_codes(codes);
                for (int k = 15; k >= 0; k--) begin
                        ch = codes[k*8 +: 8];
                        if (ch != 8'h00) begin
                                remaining--;
                                @(negedge clk);
                                test_name = line_names[index];
                                sym       = sym_t'(ch - 8'h30);
                                check_en  = 1'b1;
                                // only the final commit lights the display
                                expected  = (remaining == 0) ? line_expected[index]
                                                             : `MORSE_SEG_BLANK;
                                if (remaining > 0) begin
                                        idle_run = int'($urandom % (MAX_IDLE + 1));
                                        repeat (idle_run) begin
                                                @(negedge clk);
                                                sym      = `MORSE_SYM_IDLE;
                                                expected = `MORSE_SEG_BLANK;
                                        end
                                end
                        end
                end
        endtask

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit > 0 && cycle_count > cycle_limit) begin
                        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                        $display("FAIL: see errors above");
                        $finish;
                end
        end

        initial begin
                int   code_count;
                logic load_ok;
                rst       = 1'b0;
                sym       = `MORSE_SYM_IDLE;
                expected  = `MORSE_SEG_BLANK;
                test_name = '0;
                check_en  = 1'b0;
                flush     = 1'b0;
                void'($urandom(32'hb622_5e7f));
                load_stimulus(code_count, load_ok);
                if (!load_ok) begin
                        $display("FAIL: see errors above");
                        $finish;
                end else begin
                        cycle_limit = RESET_CYCLES + code_count * (1 + MAX_IDLE) + MARGIN;
                        repeat (RESET_CYCLES) @(negedge clk);
                        rst = 1'b1;
                        for (int i = 0; i < line_names.size(); i++) begin
                                play_line(i);
                        end
                        @(negedge clk);
                        check_en = 1'b0;
                        sym      = `MORSE_SYM_IDLE;
                        flush    = 1'b1;    // closes the last test and prints the counts
                        while (!report_done) begin
                                @(negedge clk);
                        end
                        if (checks_failed == 0 && tests_failed == 0 && checks_run > 0) begin
                                $display("PASS: all tests");
                        end else begin
                                $display("FAIL: see errors above");
                        end
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/morse_pkg.sv
logic/morse_tree.sv
logic/segment_driver.sv
logic/morse_decoder.sv
verification/morse_checker.sv
verification/tb_morse_decoder.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns -f all.f \
        --top-module tb_morse_decoder -o tb_morse_decoder &&
./obj_dir/tb_morse_decoder | tee sim.log &&
test -s sim.log &&
! grep -q "FAIL: see errors above" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verification/morse_stimulus.txt
# columns: test name, symbol codes one digit per cycle (0 idle, 1 dot, 2 dash,
# 3 letter end, 4 word gap, 5-7 invalid), segments expected after the last code
reset_blank 0 ff
root_commit 3 ff
letter_a 123 88
letter_b 21113 83
letter_c 21213 c6
letter_d 2113 a1
letter_e 13 86
letter_f 11213 8e
letter_g 2213 c2
letter_h 11113 89
letter_i 113 cf
letter_j 12223 e1
letter_k 2123 8a
letter_l 12113 c7
letter_m 223 aa
letter_n 213 ab
letter_o 2223 c0
letter_p 12213 8c
letter_q 22123 98
letter_r 1213 9e
letter_s 1113 92
letter_t 23 87
letter_u 1123 c1
letter_v 11123 e3
letter_w 1223 d5
letter_x 21123 89
letter_y 21223 91
letter_z 22113 a4
digit_1 122223 f9
digit_2 112223 a4
digit_3 111223 b0
digit_4 111123 99
digit_5 111113 92
digit_6 211113 82
digit_7 221113 f8
digit_8 222113 80
node_ds1 22213 ff
node_ds3 11223 ff
idle_inside 10002003 88
idle_long 200000000113 a1
gap_mid 214 f7
gap_restart 13 86
gap_at_root 4 f7
bad_code_5 1253 ff
bad_code_6 1163 ff
bad_code_7 2273 ff
past_leaf_r 12123 ff
past_leaf_5 1111113 ff
after_abort 1123 c1
